//--- macPipe_stim.txt
// mode (0 normal, 1 short), sample (8-bit hex, two's complement), coefficient (4-bit hex)
// normal items, short items with upper coefficient bits set, then a run of large products
0 05 3
0 fb 7
0 80 f
0 7f f
0 80 0
0 c3 a
0 01 1
1 7f f
1 80 e
1 9c 5
1 12 c
1 ff 7
0 80 f
0 80 f
0 80 f
0 7f f
0 7f f
0 7f f
0 7f f
1 80 b
1 80 b
0 00 9
0 40 8

//--- macPipe.f
+incdir+.
macSeqPkg.sv
macDataPkg.sv
macSequencer.sv
macOperandStage.sv
macSerialMultiplier.sv
macAccumulateStage.sv
macPipe.sv
macPipe_tb.sv

//--- Bender.yml
package:
  name: macPipe

export_include_dirs:
  - .

sources:
  - files:
      - macSeqPkg.sv
      - macDataPkg.sv
      - macSequencer.sv
      - macOperandStage.sv
      - macSerialMultiplier.sv
      - macAccumulateStage.sv
      - macPipe.sv
  - target: simulation
    files:
      - macPipe_tb.sv

//--- macPipe_tb.sv
// testbench for the multiply-accumulate pipeline that checks products, sums, latency and spacing
`timescale 1ns/1ns
`include "macPipe_params.svh"

module macPipe_tb;
   import macDataPkg::*;

   logic   Clock;
   logic   rstN;
   logic   inValid;
   logic   shortMode;
   sampleT inSample;
   coefT   inCoef;
   logic   inTaken;
   logic   outValid;
   accT    outProduct;
   accT    outSum;

   // items read from the stimulus file, in input order
   logic   itemShort[$];
   sampleT itemSample[$];
   coefT   itemCoef[$];
   bit     stimLoaded;

   // expectations per accepted item, oldest at the front
   accT    expProductQ[$];
   accT    expSumQ[$];
   logic   expShortQ[$];
   int     takenCycleQ[$];
   accT    runningSum;

   logic [31:0] lfsrState;
   int          cycleCount;
   int          lastTakenCycle;
   int          outCount;
   bit          haveTaken;

   macPipe macPipe_inst (
      .Clock      (Clock),
      .rstN       (rstN),
      .inValid    (inValid),
      .shortMode  (shortMode),
      .inSample   (inSample),
      .inCoef     (inCoef),
      .inTaken    (inTaken),
      .outValid   (outValid),
      .outProduct (outProduct),
      .outSum     (outSum)
   );

   always #4 Clock = ~Clock;

   // ********************************************************************
   // helpers
   // ********************************************************************

   // prints the error line, then stops the run
   task automatic flagMismatch(input string msg);
      $display("Error at %0t ns: %s", $time, msg);
      $display("Something failed");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic compareAcc(input accT actual, input accT expected, input string what);
      if (actual !== expected) begin
         flagMismatch($sformatf("%s is %h, expected %h", what, actual, expected));
      end
   endtask

   task automatic compareLatency(input int actual, input int expected, input string what);
      if (actual != expected) begin
         flagMismatch($sformatf("%s is %0d cycles, expected %0d", what, actual, expected));
      end
   endtask

   // Fibonacci LFSR for x^32 + x^22 + x^2 + x + 1
   // the new bit enters at position 0
   function automatic logic [31:0] nextLfsr(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // signed sample times the coefficient
   // only the low coefficient bits count in short mode
   function automatic accT expectProduct(input sampleT s, input coefT c, input logic isShort);
      coefT effCoef;
      int   full;
      effCoef = isShort ? coefT'(int'(c) % (1 << `MAC_SHORT_BITS)) : c;
      full    = int'(s) * int'(effCoef);
      return accT'(full);
   endfunction

   task automatic loadStimulus();
      int    fd;
      int    code;
      int    m;
      int    s;
      int    c;
      string line;
      fd = $fopen("macPipe_stim.txt", "r");
      if (fd == 0) begin
         $display("could not open the stimulus file macPipe_stim.txt");
         $display("Something failed");
         $fatal(1, "no stimulus");
      end
      while (!$feof(fd)) begin
         code = $fgets(line, fd);
         // comment lines and blank lines are skipped
         if (code > 0 && line.substr(0, 1) != "//") begin
            if ($sscanf(line, "%h %h %h", m, s, c) == 3) begin
               itemShort.push_back(m[0]);
               itemSample.push_back(sampleT'(s));
               itemCoef.push_back(coefT'(c));
            end
         end
      end
      $fclose(fd);
   endtask

   // blocks until every accepted item has produced its result
   task automatic waitForDrain();
      while (expProductQ.size() != 0) begin
         @(negedge Clock);
      end
   endtask

   // two LFSR bits pick an idle gap of zero to three cycles
   task automatic drawGap(output int gap);
      logic hiBit;
      lfsrState = nextLfsr(lfsrState);
      hiBit     = lfsrState[0];
      lfsrState = nextLfsr(lfsrState);
      gap       = {hiBit, lfsrState[0]};
   endtask

   // ********************************************************************
   // stimulus driver
   // ********************************************************************

   initial begin : driveItems
      int gap;
      Clock      = 1'b0;
      rstN       = 1'b0;
      inValid    = 1'b0;
      shortMode  = 1'b0;
      inSample   = '0;
      inCoef     = '0;
      runningSum = '0;
      lfsrState  = 32'h56738942;
      loadStimulus();
      stimLoaded = 1'b1;
      repeat (4) @(posedge Clock);
      @(negedge Clock);
      rstN = 1'b1;
      compareAcc(outSum, '0, "sum after reset");
      // the monitor flags any strobe during this quiet stretch
      repeat (5) @(negedge Clock);
      for (int i = 0; i < itemShort.size(); i++) begin
         drawGap(gap);
         if (itemShort[i] != shortMode) begin
            // the mode may only move while nothing is in flight
            inValid = 1'b0;
            waitForDrain();
            shortMode = itemShort[i];
         end else if (gap > 0) begin
            inValid = 1'b0;
            repeat (gap) @(negedge Clock);
         end
         inSample   = itemSample[i];
         inCoef     = itemCoef[i];
         inValid    = 1'b1;
         runningSum = runningSum + expectProduct(itemSample[i], itemCoef[i], itemShort[i]);
         expProductQ.push_back(expectProduct(itemSample[i], itemCoef[i], itemShort[i]));
         expSumQ.push_back(runningSum);
         expShortQ.push_back(itemShort[i]);
         // hold the item until a rising edge sees it taken
         do begin
            @(posedge Clock);
         end while (!inTaken);
         @(negedge Clock);
      end
      inValid = 1'b0;
      waitForDrain();
      repeat (3) @(negedge Clock);
      $display("Everything OK");
      $finish;
   end

   // ********************************************************************
   // output monitor
   // ********************************************************************

   // values read at the rising edge are the ones of the cycle that ends there
   always @(posedge Clock) begin : monitorOutputs
      int   tookAt;
      int   minSpacing;
      logic wasShort;
      if (rstN) begin
         cycleCount++;
         if (inTaken) begin
            if (!inValid) begin
               flagMismatch("inTaken pulsed while inValid was low");
            end
            minSpacing = shortMode ? 3 : 6;
            if (haveTaken && (cycleCount - lastTakenCycle) < minSpacing) begin
               flagMismatch($sformatf("taken pulses %0d cycles apart, at least %0d needed",
                                      cycleCount - lastTakenCycle, minSpacing));
            end
            haveTaken      = 1'b1;
            lastTakenCycle = cycleCount;
            takenCycleQ.push_back(cycleCount);
         end
         if (outValid) begin
            if (expProductQ.size() == 0 || takenCycleQ.size() == 0) begin
               flagMismatch("outValid pulsed with no item in flight");
            end
            tookAt   = takenCycleQ.pop_front();
            wasShort = expShortQ.pop_front();
            if (outCount == 0) begin
               // the accumulator starts from zero, so the first sum is the first product
               compareAcc(outSum, expProductQ[0], "first sum against first product");
            end
            compareAcc(outProduct, expProductQ.pop_front(),
                       $sformatf("product of result %0d", outCount));
            compareAcc(outSum, expSumQ.pop_front(), $sformatf("sum of result %0d", outCount));
            compareLatency(cycleCount - tookAt, wasShort ? 5 : 7,
                           $sformatf("latency of result %0d", outCount));
            outCount++;
         end
      end
   end

   // watchdog limit grows with the number of items
   initial begin : watchdog
      wait (stimLoaded);
      repeat (itemShort.size() * 20 + 100) @(posedge Clock);
      $display("Timeout: the pipeline stopped producing results after %0d results", outCount);
      $display("Something failed");
      $fatal(1, "watchdog expired");
   end

endmodule

//--- macPipe.sv
// multiply-accumulate pipeline top with sequencer and three stages
`timescale 1ns/1ns

module macPipe (
   input  logic               Clock,
   input  logic               rstN,
   input  logic               inValid,
   input  logic               shortMode,
   input  macDataPkg::sampleT inSample,
   input  macDataPkg::coefT   inCoef,
   output logic               inTaken,
   output logic               outValid,
   output macDataPkg::accT    outProduct,
   output macDataPkg::accT    outSum
);
   import macSeqPkg::*;
   import macDataPkg::*;

   stageStarts starts;
   operandWord operand;
   productWord product;

   // the source sees its item taken when the operand stage starts
   assign inTaken = starts.startOperand;

   macSequencer macSequencer_inst (
      .Clock     (Clock),
      .rstN      (rstN),
      .inValid   (inValid),
      .shortMode (shortMode),
      .starts    (starts)
   );

   macOperandStage macOperandStage_inst (
      .Clock     (Clock),
      .rstN      (rstN),
      .start     (starts.startOperand),
      .sample    (inSample),
      .coef      (inCoef),
      .shortMode (shortMode),
      .operand   (operand)
   );

   macSerialMultiplier macSerialMultiplier_inst (
      .Clock   (Clock),
      .rstN    (rstN),
      .start   (starts.startMultiply),
      .operand (operand),
      .product (product)
   );

   macAccumulateStage macAccumulateStage_inst (
      .Clock      (Clock),
      .rstN       (rstN),
      .start      (starts.startAccumulate),
      .product    (product),
      .outValid   (outValid),
      .outProduct (outProduct),
      .outSum     (outSum)
   );

endmodule

//--- macAccumulateStage.sv
// accumulate stage that restores the sign and adds into the wrapping sum
`timescale 1ns/1ns

module macAccumulateStage (
   input  logic                   Clock,
   input  logic                   rstN,
   input  logic                   start,
   input  macDataPkg::productWord product,
   output logic                   outValid,
   output macDataPkg::accT        outProduct,
   output macDataPkg::accT        outSum
);
   import macDataPkg::*;

   accT signedProduct;
   accT sumReg;

   // two's complement negate of the magnitude product
   assign signedProduct = product.negative ? accT'(-product.product) : product.product;

   // *********************************************************************
   // accumulator and valid pulse
   // *********************************************************************

   // the sum wraps silently at the accumulator width
   always_ff @(posedge Clock) begin
      if (!rstN) begin
         outValid <= 1'b0;
         sumReg   <= '0;
      end else begin
         // one pulse per accumulated item
         outValid <= start;
         if (start) begin
            sumReg <= sumReg + signedProduct;
         end
      end
   end

   // product seen together with the sum it went into
   always_ff @(posedge Clock) begin
      if (start) begin
         outProduct <= signedProduct;
      end
   end

   assign outSum = sumReg;

endmodule

//--- macSerialMultiplier.sv
// shift-add serial multiplier whose step count follows the item's mode
`timescale 1ns/1ns
`include "macPipe_params.svh"

module macSerialMultiplier (
   input  logic                   Clock,
   input  logic                   rstN,
   input  logic                   start,
   input  macDataPkg::operandWord operand,
   output macDataPkg::productWord product
);
   import macDataPkg::*;

   typedef enum logic {
      mulIdle,
      mulBusy
   } mulState;

   localparam int StepW = $clog2(`MAC_COEF_WIDTH);

   mulState          state;
   logic [StepW-1:0] stepsLeft;

   // shifted magnitude, remaining coefficient bits and running partial sum
   accT              multiplicand;
   coefT             coefBits;
   accT              partialSum;
   logic             negativeHeld;

   coefT             modeMask;
   accT              firstTerm;

   // short mode keeps only the low coefficient bits
   assign modeMask  = operand.shortMode ? coefT'((1 << `MAC_SHORT_BITS) - 1) : '1;

   // the start cycle already handles coefficient bit 0 so that
   // the product is ready four (or two) cycles after start
   assign firstTerm = operand.coef[0] ? accT'(operand.magnitude) : '0;

   // *********************************************************************
   // step control
   // *********************************************************************

   always_ff @(posedge Clock) begin
      if (!rstN) begin
         state     <= mulIdle;
         stepsLeft <= '0;
      end else if (start) begin
         state     <= mulBusy;
         stepsLeft <= operand.shortMode ? StepW'(`MAC_SHORT_BITS - 1)
                                        : StepW'(`MAC_COEF_WIDTH - 1);
      end else if (state == mulBusy) begin
         stepsLeft <= stepsLeft - 1'b1;
         if (stepsLeft == StepW'(1)) begin
            state <= mulIdle;
         end
      end
   end

   // *********************************************************************
   // shift-add datapath
   // *********************************************************************

   always_ff @(posedge Clock) begin
      if (start) begin
         // partial sum restarts from the bit 0 term
         multiplicand <= accT'(operand.magnitude) << 1;
         coefBits     <= (operand.coef & modeMask) >> 1;
         partialSum   <= firstTerm;
         negativeHeld <= operand.negative;
      end else if (state == mulBusy) begin
         if (coefBits[0]) begin
            partialSum <= partialSum + multiplicand;
         end
         multiplicand <= multiplicand << 1;
         coefBits     <= coefBits >> 1;
      end
   end

   // the result stays put while idle until the next start
   assign product = {partialSum, negativeHeld};

   // the sequencer schedule must leave the multiplier free before each start
   assert property (@(posedge Clock) disable iff (!rstN)
      start |-> (state == mulIdle))
      else $error("multiplier started while still busy");

endmodule

//--- macOperandStage.sv
// operand stage that captures an item and splits the sample into magnitude and sign
`timescale 1ns/1ns
`include "macPipe_params.svh"

module macOperandStage (
   input  logic                   Clock,
   input  logic                   rstN,
   input  logic                   start,
   input  macDataPkg::sampleT     sample,
   input  macDataPkg::coefT       coef,
   input  logic                   shortMode,
   output macDataPkg::operandWord operand
);
   import macDataPkg::*;

   // first register rank, loaded on start
   sampleT heldSample;
   coefT   heldCoef;
   logic   heldShort;

   // set for the one cycle in which the second rank is loaded
   logic   formPending;

   logic   sampleNegative;

   assign sampleNegative = heldSample[`MAC_SAMPLE_WIDTH-1];

   always_ff @(posedge Clock) begin
      if (!rstN) begin
         formPending <= 1'b0;
      end else begin
         formPending <= start;
      end
   end

   // capture the item as the sequencer takes it
   always_ff @(posedge Clock) begin
      if (start) begin
         heldSample <= sample;
         heldCoef   <= coef;
         heldShort  <= shortMode;
      end
   end

   // second rank holds its value until the cycle after the next start
   // negating -128 in eight bits gives 8'h80, which read unsigned is 128
   always_ff @(posedge Clock) begin
      if (formPending) begin
         operand.magnitude <= sampleNegative ? $unsigned(-heldSample)
                                             : $unsigned(heldSample);
         operand.negative  <= sampleNegative;
         operand.coef      <= heldCoef;
         operand.shortMode <= heldShort;
      end
   end

endmodule

//--- macSequencer.sv
// master sequencer that issues the operand, multiply and accumulate starts
`timescale 1ns/1ns

module macSequencer (
   input  logic                  Clock,
   input  logic                  rstN,
   input  logic                  inValid,
   input  logic                  shortMode,
   output macSeqPkg::stageStarts starts
);
   import macSeqPkg::*;

   seqState state;
   seqState nextState;

   // *********************************************************************
   // state register
   // *********************************************************************

   always_ff @(posedge Clock) begin
      if (!rstN) begin
         state <= stIdle;
      end else begin
         state <= nextState;
      end
   end

   // *********************************************************************
   // next state and strobes
   // *********************************************************************

   // inValid is only looked at in stIdle, stNormAcc and stShortSample
   // every other state just walks the fixed schedule
   always_comb begin
      starts    = '0;
      nextState = stIdle;
      case (state)
         stIdle: begin
            if (inValid) begin
               starts.startOperand = 1'b1;
               // the mode is latched into the schedule here and nowhere else
               nextState = shortMode ? stShortWait : stNormWait1;
            end else begin
               nextState = stIdle;
            end
         end
         stNormWait1: nextState = stNormMul;
         stNormMul: begin
            // operand word is ready two cycles after its start
            starts.startMultiply = 1'b1;
            nextState            = stNormWait3;
         end
         stNormWait3: nextState = stNormWait4;
         stNormWait4: nextState = stNormWait5;
         stNormWait5: nextState = stNormAcc;
         stNormAcc: begin
            // the product is done here and a new item may enter in the same cycle
            starts.startAccumulate = 1'b1;
            if (inValid) begin
               starts.startOperand = 1'b1;
               nextState           = stNormWait1;
            end else begin
               nextState = stIdle;
            end
         end
         stShortWait: nextState = stShortMul;
         stShortMul: begin
            starts.startMultiply = 1'b1;
            nextState            = stShortSample;
         end
         stShortSample: begin
            // steady-state point of the short schedule
            // a new item overlaps the accumulate of the current one
            if (inValid) begin
               starts.startOperand = 1'b1;
               nextState           = stShortAcc;
            end else begin
               nextState = stShortDrain;
            end
         end
         stShortAcc: begin
            starts.startAccumulate = 1'b1;
            nextState              = stShortMul2;
         end
         stShortMul2: begin
            // multiply for the item taken two cycles earlier
            starts.startMultiply = 1'b1;
            nextState            = stShortSample;
         end
         stShortDrain: begin
            // last item in flight finishes and the pipe goes idle
            starts.startAccumulate = 1'b1;
            nextState              = stIdle;
         end
         default: nextState = stIdle;
      endcase
   end

   // *********************************************************************
   // checks
   // *********************************************************************

   // the state register must stay inside the thirteen legal codes
   assert property (@(posedge Clock) disable iff (!rstN)
      !$isunknown(state) && (state <= stShortDrain))
      else $error("sequencer state left the legal encoding");

   // the multiplier and accumulator must never be started together
   // since the accumulator reads a finished product
   assert property (@(posedge Clock) disable iff (!rstN)
      !(starts.startAccumulate && starts.startMultiply))
      else $error("accumulate and multiply started in the same cycle");

endmodule

//--- macDataPkg.sv
// data types passed between the stages of the multiply-accumulate pipeline
`include "macPipe_params.svh"

package macDataPkg;

   // *********************************************************************
   // scalar types
   // *********************************************************************

   // signed input sample
   typedef logic signed [`MAC_SAMPLE_WIDTH-1:0] sampleT;

   // unsigned coefficient
   typedef logic [`MAC_COEF_WIDTH-1:0] coefT;

   // product or running sum, two's complement, wraps at full width
   typedef logic [`MAC_ACC_WIDTH-1:0] accT;

   // *********************************************************************
   // stage to stage words
   // *********************************************************************

   // operand stage output
   // magnitude is unsigned so that -128 maps to 128 without overflow
   // the mode travels with the item so the multiplier never looks
   // at the live mode input
   typedef struct packed {
      logic [`MAC_SAMPLE_WIDTH-1:0] magnitude;
      logic                         negative;
      coefT                         coef;
      logic                         shortMode;
   } operandWord;

   // multiplier output
   // the product is the unsigned magnitude product and the sign is
   // restored in the accumulate stage
   typedef struct packed {
      accT  product;
      logic negative;
   } productWord;

endpackage

//--- macSeqPkg.sv
// sequencer types for the multiply-accumulate pipeline control
package macSeqPkg;

   // the thirteen master states
   // stNorm* states run the six-cycle normal schedule
   // stShort* states run the three-cycle overlapped short schedule
   typedef enum logic [3:0] {
      stIdle        = 4'd0,
      stNormWait1   = 4'd1,
      stNormMul     = 4'd2,
      stNormWait3   = 4'd3,
      stNormWait4   = 4'd4,
      stNormWait5   = 4'd5,
      stNormAcc     = 4'd6,
      stShortWait   = 4'd7,
      stShortMul    = 4'd8,
      stShortSample = 4'd9,
      stShortAcc    = 4'd10,
      stShortMul2   = 4'd11,
      stShortDrain  = 4'd12
   } seqState;

   // one-cycle start strobes for the three processing stages
   // the first strobe also serves as the taken pulse seen by the source
   typedef struct packed {
      logic startOperand;
      logic startMultiply;
      logic startAccumulate;
   } stageStarts;

endpackage

//--- macPipe_params.svh
// multiply-accumulate pipeline widths and per-mode coefficient bit counts
`ifndef MAC_PIPE_PARAMS_SVH
`define MAC_PIPE_PARAMS_SVH

// *********************************************************************
// data widths
// *********************************************************************

// the input sample is a signed two's-complement value
`define MAC_SAMPLE_WIDTH 8

// the coefficient is unsigned and is consumed one bit per multiplier step
`define MAC_COEF_WIDTH 4

// products and the running sum share this width and wrap on overflow
`define MAC_ACC_WIDTH 16

// *********************************************************************
// mode dependent coefficient bits
// *********************************************************************

// in short mode only the low coefficient bits take part in the product
// normal mode uses the full MAC_COEF_WIDTH
`define MAC_SHORT_BITS 2

`endif
